//--- hdl/soc_pkg.sv
package soc_pkg;

	localparam int XLEN = 32;

	typedef logic [XLEN-1:0]   addr_t;
	typedef logic [XLEN-1:0]   data_t;
	typedef logic [XLEN/8-1:0] strb_t;	// one bit per byte lane

	// same encoding as the AXI resp field
	typedef enum logic [1:0] {
		RESP_OKAY   = 2'd0,
		RESP_SLVERR = 2'd2,
		RESP_DECERR = 2'd3
	} resp_e;

	typedef enum logic {
		OP_READ  = 1'b0,
		OP_WRITE = 1'b1
	} bus_op_e;

	// crossbar target
	typedef enum logic [1:0] {
		DEV_SRAM,
		DEV_UART,
		DEV_CLINT,
		DEV_NONE
	} dev_e;

	// address map
	localparam addr_t SRAM_BASE      = 32'h8000_0000;
	localparam addr_t UART_TX_ADDR   = 32'ha000_03f8;
	localparam addr_t CLINT_MTIME_LO = 32'ha000_0048;
	localparam addr_t CLINT_MTIME_HI = 32'ha000_004c;

	// data write port payload
	typedef struct packed {
		addr_t addr;
		data_t data;
		strb_t strb;
	} wr_req_t;

	// internal request, one beat
	typedef struct packed {
		bus_op_e op;
		addr_t   addr;
		data_t   data;
		strb_t   strb;
	} bus_req_t;

	// internal response, also read port payload
	typedef struct packed {
		data_t data;
		resp_e resp;
	} bus_rsp_t;

endpackage

//--- hdl/sram_dev.sv
module sram_dev #(
	parameter int SRAM_AW = 10
) (
	input  logic              clock,
	input  logic              req_valid_i,
	input  soc_pkg::bus_req_t req_i,
	output logic              rsp_valid_o,
	output soc_pkg::bus_rsp_t rsp_o
);

	localparam int DEPTH = 1 << SRAM_AW;
	localparam int LANES = soc_pkg::XLEN / 8;

	soc_pkg::data_t     mem [DEPTH];
	logic [SRAM_AW-1:0] word_idx;
	logic               wr_en;

	// byte offset bits are ignored
	assign word_idx = req_i.addr[SRAM_AW+1:2];
	assign wr_en    = req_valid_i && (req_i.op == soc_pkg::OP_WRITE);

	// byte lane writes
	always_ff @(posedge clock) begin
		if (wr_en) begin
			for (int b = 0; b < LANES; b++) begin
				if (req_i.strb[b])
					mem[word_idx][b*8 +: 8] <= req_i.data[b*8 +: 8];
			end
		end
	end

	// response one cycle after the request
	always_ff @(posedge clock) begin
		rsp_valid_o <= req_valid_i;
		if (req_valid_i) begin
			rsp_o.data <= wr_en ? '0 : mem[word_idx];	// old word on read
			rsp_o.resp <= soc_pkg::RESP_OKAY;
		end
	end

endmodule

//--- hdl/uart_dev.sv
module uart_dev (
	input  logic           clock,
	input  logic           rst_n_i,
	input  logic           req_valid_i,
	input  soc_pkg::data_t req_data_i,
	output logic           rsp_valid_o,
	output soc_pkg::resp_e rsp_resp_o,
	output logic           tx_valid_o,
	output logic [7:0]     tx_byte_o
);

	logic       tx_valid_q;
	logic [7:0] tx_byte_q;

	always_ff @(posedge clock) begin
		if (!rst_n_i)
			tx_valid_q <= 1'b0;
		else
			tx_valid_q <= req_valid_i;	// one pulse per write
	end

	// only the low byte goes out
	always_ff @(posedge clock) begin
		if (req_valid_i)
			tx_byte_q <= req_data_i[7:0];
	end

	assign tx_valid_o = tx_valid_q;
	assign tx_byte_o  = tx_byte_q;

	// write is acked together with the tx pulse
	assign rsp_valid_o = tx_valid_q;
	assign rsp_resp_o  = soc_pkg::RESP_OKAY;

endmodule

//--- hdl/clint_dev.sv
module clint_dev (
	input  logic              clock,
	input  logic              rst_n_i,
	input  logic              req_valid_i,
	input  soc_pkg::addr_t    req_addr_i,
	output logic              rsp_valid_o,
	output soc_pkg::bus_rsp_t rsp_o
);

	logic [63:0]    mtime_q;
	logic           rsp_valid_q;
	soc_pkg::data_t rsp_data_q;

	always_ff @(posedge clock) begin
		if (!rst_n_i) begin
			mtime_q     <= '0;
			rsp_valid_q <= 1'b0;
		end else begin
			mtime_q     <= mtime_q + 64'd1;	// free running
			rsp_valid_q <= req_valid_i;
		end
	end

	// bit 2 picks the half, value taken at the request cycle
	always_ff @(posedge clock) begin
		if (req_valid_i)
			rsp_data_q <= req_addr_i[2] ? mtime_q[63:32] : mtime_q[31:0];
	end

	assign rsp_valid_o = rsp_valid_q;
	assign rsp_o.data  = rsp_data_q;
	assign rsp_o.resp  = soc_pkg::RESP_OKAY;

endmodule

//--- hdl/addr_xbar.sv
module addr_xbar #(
	parameter int SRAM_AW = 10
) (
	input  logic              clock,
	input  logic              rst_n_i,
	input  logic              bus_req_valid_i,
	input  soc_pkg::bus_req_t bus_req_i,
	output logic              bus_rsp_valid_o,
	output soc_pkg::bus_rsp_t bus_rsp_o,
	// sram
	output logic              sram_req_valid_o,
	output soc_pkg::bus_req_t sram_req_o,
	input  logic              sram_rsp_valid_i,
	input  soc_pkg::bus_rsp_t sram_rsp_i,
	// uart, write data only
	output logic              uart_req_valid_o,
	output soc_pkg::data_t    uart_req_data_o,
	input  logic              uart_rsp_valid_i,
	input  soc_pkg::resp_e    uart_rsp_resp_i,
	// clint, address only
	output logic              clint_req_valid_o,
	output soc_pkg::addr_t    clint_req_addr_o,
	input  logic              clint_rsp_valid_i,
	input  soc_pkg::bus_rsp_t clint_rsp_i
);

	// sram window is 2^SRAM_AW words
	localparam soc_pkg::addr_t SRAM_SPAN = soc_pkg::addr_t'(4) << SRAM_AW;
	localparam soc_pkg::addr_t SRAM_END  = soc_pkg::SRAM_BASE + SRAM_SPAN;

	soc_pkg::dev_e dev_sel;
	soc_pkg::dev_e dev_q;	// target of the request in flight
	logic          is_write;
	logic          decerr_q;

	assign is_write = (bus_req_i.op == soc_pkg::OP_WRITE);

	always_comb begin
		if (bus_req_i.addr >= soc_pkg::SRAM_BASE && bus_req_i.addr < SRAM_END) begin
			dev_sel = soc_pkg::DEV_SRAM;
		end else if (is_write && bus_req_i.addr == soc_pkg::UART_TX_ADDR) begin
			dev_sel = soc_pkg::DEV_UART;
		end else if (!is_write && (bus_req_i.addr == soc_pkg::CLINT_MTIME_LO
				|| bus_req_i.addr == soc_pkg::CLINT_MTIME_HI)) begin
			dev_sel = soc_pkg::DEV_CLINT;
		end else begin
			dev_sel = soc_pkg::DEV_NONE;	// uart read, clint write land here too
		end
	end

	assign sram_req_valid_o  = bus_req_valid_i && (dev_sel == soc_pkg::DEV_SRAM);
	assign uart_req_valid_o  = bus_req_valid_i && (dev_sel == soc_pkg::DEV_UART);
	assign clint_req_valid_o = bus_req_valid_i && (dev_sel == soc_pkg::DEV_CLINT);
	assign sram_req_o        = bus_req_i;
	assign uart_req_data_o   = bus_req_i.data;
	assign clint_req_addr_o  = bus_req_i.addr;

	always_ff @(posedge clock) begin
		if (!rst_n_i) begin
			dev_q    <= soc_pkg::DEV_NONE;
			decerr_q <= 1'b0;
		end else begin
			if (bus_req_valid_i)
				dev_q <= dev_sel;
			decerr_q <= bus_req_valid_i && (dev_sel == soc_pkg::DEV_NONE);
		end
	end

	// return path, one strobe per request
	always_comb begin
		case (dev_q)
			soc_pkg::DEV_SRAM: begin
				bus_rsp_valid_o = sram_rsp_valid_i;
				bus_rsp_o       = sram_rsp_i;
			end
			soc_pkg::DEV_UART: begin
				bus_rsp_valid_o = uart_rsp_valid_i;
				bus_rsp_o.data  = '0;
				bus_rsp_o.resp  = uart_rsp_resp_i;
			end
			soc_pkg::DEV_CLINT: begin
				bus_rsp_valid_o = clint_rsp_valid_i;
				bus_rsp_o       = clint_rsp_i;
			end
			default: begin
				bus_rsp_valid_o = decerr_q;
				bus_rsp_o.data  = '0;
				bus_rsp_o.resp  = soc_pkg::RESP_DECERR;
			end
		endcase
	end

endmodule

//--- hdl/bus_ctl.sv
module bus_ctl (
	input  logic              clock,
	input  logic              rst_n_i,
	// instruction fetch
	input  logic              inst_req_valid_i,
	input  soc_pkg::addr_t    inst_req_addr_i,
	output logic              inst_req_ready_o,
	output logic              inst_rsp_valid_o,
	output soc_pkg::bus_rsp_t inst_rsp_o,
	input  logic              inst_rsp_ready_i,
	// data read
	input  logic              rd_req_valid_i,
	input  soc_pkg::addr_t    rd_req_addr_i,
	output logic              rd_req_ready_o,
	output logic              rd_rsp_valid_o,
	output soc_pkg::bus_rsp_t rd_rsp_o,
	input  logic              rd_rsp_ready_i,
	// data write
	input  logic              wr_req_valid_i,
	input  soc_pkg::wr_req_t  wr_req_i,
	output logic              wr_req_ready_o,
	output logic              wr_rsp_valid_o,
	output soc_pkg::resp_e    wr_rsp_o,
	input  logic              wr_rsp_ready_i,
	// internal bus
	output logic              bus_req_valid_o,
	output soc_pkg::bus_req_t bus_req_o,
	input  logic              bus_rsp_valid_i,
	input  soc_pkg::bus_rsp_t bus_rsp_i
);

	typedef enum logic [1:0] {CTL_IDLE, CTL_ISSUE, CTL_WAIT, CTL_RESP} ctl_state_e;
	typedef enum logic [1:0] {PORT_INST, PORT_RD, PORT_WR} port_e;

	ctl_state_e        state_q;
	ctl_state_e        state_d;
	port_e             owner_q;	// port that got the grant
	soc_pkg::bus_req_t req_q;
	soc_pkg::bus_rsp_t rsp_q;
	soc_pkg::bus_rsp_t rsp_cur;
	logic              idle;
	logic              grant;
	logic              rsp_valid;
	logic              rsp_ready;

	// fixed priority: write, data read, fetch
	assign idle             = (state_q == CTL_IDLE);
	assign wr_req_ready_o   = idle && wr_req_valid_i;
	assign rd_req_ready_o   = idle && rd_req_valid_i && !wr_req_valid_i;
	assign inst_req_ready_o = idle && inst_req_valid_i && !rd_req_valid_i
		&& !wr_req_valid_i;
	assign grant = wr_req_ready_o || rd_req_ready_o || inst_req_ready_o;

	assign bus_req_valid_o = (state_q == CTL_ISSUE);
	assign bus_req_o       = req_q;

	// bus data passes through on the strobe cycle, the buffer holds it after that
	assign rsp_valid = (state_q == CTL_RESP) || (state_q == CTL_WAIT && bus_rsp_valid_i);
	assign rsp_cur   = (state_q == CTL_WAIT) ? bus_rsp_i : rsp_q;

	assign inst_rsp_valid_o = rsp_valid && (owner_q == PORT_INST);
	assign rd_rsp_valid_o   = rsp_valid && (owner_q == PORT_RD);
	assign wr_rsp_valid_o   = rsp_valid && (owner_q == PORT_WR);
	assign inst_rsp_o       = rsp_cur;
	assign rd_rsp_o         = rsp_cur;
	assign wr_rsp_o         = rsp_cur.resp;	// write side only sees the code

	always_comb begin
		case (owner_q)
			PORT_WR: rsp_ready = wr_rsp_ready_i;
			PORT_RD: rsp_ready = rd_rsp_ready_i;
			default: rsp_ready = inst_rsp_ready_i;
		endcase
	end

	always_comb begin
		state_d = state_q;
		case (state_q)
			CTL_IDLE: begin
				if (grant)
					state_d = CTL_ISSUE;
			end
			CTL_ISSUE: state_d = CTL_WAIT;
			CTL_WAIT: begin
				if (bus_rsp_valid_i)
					state_d = rsp_ready ? CTL_IDLE : CTL_RESP;
			end
			CTL_RESP: begin
				if (rsp_ready)
					state_d = CTL_IDLE;
			end
			default: state_d = CTL_IDLE;
		endcase
	end

	always_ff @(posedge clock) begin
		if (!rst_n_i) begin
			state_q <= CTL_IDLE;
			owner_q <= PORT_INST;
		end else begin
			state_q <= state_d;
			if (wr_req_ready_o)
				owner_q <= PORT_WR;
			else if (rd_req_ready_o)
				owner_q <= PORT_RD;
			else if (inst_req_ready_o)
				owner_q <= PORT_INST;
		end
	end

	// request and response payload
	always_ff @(posedge clock) begin
		if (wr_req_ready_o) begin
			req_q.op   <= soc_pkg::OP_WRITE;
			req_q.addr <= wr_req_i.addr;
			req_q.data <= wr_req_i.data;
			req_q.strb <= wr_req_i.strb;
		end else if (rd_req_ready_o || inst_req_ready_o) begin
			req_q.op   <= soc_pkg::OP_READ;
			req_q.addr <= rd_req_ready_o ? rd_req_addr_i : inst_req_addr_i;
			req_q.data <= '0;
			req_q.strb <= '0;
		end
		if (state_q == CTL_WAIT && bus_rsp_valid_i)
			rsp_q <= bus_rsp_i;
	end

endmodule

//--- hdl/soc_top.sv
module soc_top #(
	parameter int SRAM_AW = 10
) (
	input  logic              clock,
	input  logic              rst_n_i,
	// instruction fetch
	input  logic              inst_req_valid_i,
	input  soc_pkg::addr_t    inst_req_addr_i,
	output logic              inst_req_ready_o,
	output logic              inst_rsp_valid_o,
	output soc_pkg::bus_rsp_t inst_rsp_o,
	input  logic              inst_rsp_ready_i,
	// data read
	input  logic              rd_req_valid_i,
	input  soc_pkg::addr_t    rd_req_addr_i,
	output logic              rd_req_ready_o,
	output logic              rd_rsp_valid_o,
	output soc_pkg::bus_rsp_t rd_rsp_o,
	input  logic              rd_rsp_ready_i,
	// data write
	input  logic              wr_req_valid_i,
	input  soc_pkg::wr_req_t  wr_req_i,
	output logic              wr_req_ready_o,
	output logic              wr_rsp_valid_o,
	output soc_pkg::resp_e    wr_rsp_o,
	input  logic              wr_rsp_ready_i,
	// uart byte out
	output logic              uart_tx_valid_o,
	output logic [7:0]        uart_tx_byte_o
);

	logic              bus_req_valid;
	soc_pkg::bus_req_t bus_req;
	logic              bus_rsp_valid;
	soc_pkg::bus_rsp_t bus_rsp;

	logic              sram_req_valid;
	soc_pkg::bus_req_t sram_req;
	logic              sram_rsp_valid;
	soc_pkg::bus_rsp_t sram_rsp;
	logic              uart_req_valid;
	soc_pkg::data_t    uart_req_data;
	logic              uart_rsp_valid;
	soc_pkg::resp_e    uart_rsp_resp;
	logic              clint_req_valid;
	soc_pkg::addr_t    clint_req_addr;
	logic              clint_rsp_valid;
	soc_pkg::bus_rsp_t clint_rsp;

	bus_ctl u_bus_ctl (
		.clock            (clock),
		.rst_n_i          (rst_n_i),
		.inst_req_valid_i (inst_req_valid_i),
		.inst_req_addr_i  (inst_req_addr_i),
		.inst_req_ready_o (inst_req_ready_o),
		.inst_rsp_valid_o (inst_rsp_valid_o),
		.inst_rsp_o       (inst_rsp_o),
		.inst_rsp_ready_i (inst_rsp_ready_i),
		.rd_req_valid_i   (rd_req_valid_i),
		.rd_req_addr_i    (rd_req_addr_i),
		.rd_req_ready_o   (rd_req_ready_o),
		.rd_rsp_valid_o   (rd_rsp_valid_o),
		.rd_rsp_o         (rd_rsp_o),
		.rd_rsp_ready_i   (rd_rsp_ready_i),
		.wr_req_valid_i   (wr_req_valid_i),
		.wr_req_i         (wr_req_i),
		.wr_req_ready_o   (wr_req_ready_o),
		.wr_rsp_valid_o   (wr_rsp_valid_o),
		.wr_rsp_o         (wr_rsp_o),
		.wr_rsp_ready_i   (wr_rsp_ready_i),
		.bus_req_valid_o  (bus_req_valid),
		.bus_req_o        (bus_req),
		.bus_rsp_valid_i  (bus_rsp_valid),
		.bus_rsp_i        (bus_rsp)
	);

	addr_xbar #(
		.SRAM_AW (SRAM_AW)
	) u_addr_xbar (
		.clock             (clock),
		.rst_n_i           (rst_n_i),
		.bus_req_valid_i   (bus_req_valid),
		.bus_req_i         (bus_req),
		.bus_rsp_valid_o   (bus_rsp_valid),
		.bus_rsp_o         (bus_rsp),
		.sram_req_valid_o  (sram_req_valid),
		.sram_req_o        (sram_req),
		.sram_rsp_valid_i  (sram_rsp_valid),
		.sram_rsp_i        (sram_rsp),
		.uart_req_valid_o  (uart_req_valid),
		.uart_req_data_o   (uart_req_data),
		.uart_rsp_valid_i  (uart_rsp_valid),
		.uart_rsp_resp_i   (uart_rsp_resp),
		.clint_req_valid_o (clint_req_valid),
		.clint_req_addr_o  (clint_req_addr),
		.clint_rsp_valid_i (clint_rsp_valid),
		.clint_rsp_i       (clint_rsp)
	);

	sram_dev #(
		.SRAM_AW (SRAM_AW)
	) u_sram_dev (
		.clock       (clock),
		.req_valid_i (sram_req_valid),
		.req_i       (sram_req),
		.rsp_valid_o (sram_rsp_valid),
		.rsp_o       (sram_rsp)
	);

	uart_dev u_uart_dev (
		.clock       (clock),
		.rst_n_i     (rst_n_i),
		.req_valid_i (uart_req_valid),
		.req_data_i  (uart_req_data),
		.rsp_valid_o (uart_rsp_valid),
		.rsp_resp_o  (uart_rsp_resp),
		.tx_valid_o  (uart_tx_valid_o),
		.tx_byte_o   (uart_tx_byte_o)
	);

	clint_dev u_clint_dev (
		.clock       (clock),
		.rst_n_i     (rst_n_i),
		.req_valid_i (clint_req_valid),
		.req_addr_i  (clint_req_addr),
		.rsp_valid_o (clint_rsp_valid),
		.rsp_o       (clint_rsp)
	);

endmodule

//--- bench/soc_tb.sv
module soc_tb;
	timeunit 1ns;
	timeprecision 100ps;

	localparam int CLK_PERIOD   = 8;
	localparam int RESET_CYCLES = 5;
	localparam int SRAM_AW      = 8;
	localparam int N_WORDS      = 8;	// sram words under test
	localparam int N_RAND       = 16;
	localparam int N_FETCH      = 4;
	// sram fill, random writes, readback, fetch pairs, uart, clint, decerr, arbitration
	localparam int N_TXN = 2 * N_WORDS + N_RAND + 2 * N_FETCH + 2 + 3 + 4 + N_WORDS + 6;
	localparam int WATCHDOG_NS = (RESET_CYCLES + 40 * N_TXN) * CLK_PERIOD;

	logic              clock;
	logic              rst_n;
	logic              inst_req_valid;
	soc_pkg::addr_t    inst_req_addr;
	logic              inst_req_ready;
	logic              inst_rsp_valid;
	soc_pkg::bus_rsp_t inst_rsp;
	logic              inst_rsp_ready;
	logic              rd_req_valid;
	soc_pkg::addr_t    rd_req_addr;
	logic              rd_req_ready;
	logic              rd_rsp_valid;
	soc_pkg::bus_rsp_t rd_rsp;
	logic              rd_rsp_ready;
	logic              wr_req_valid;
	soc_pkg::wr_req_t  wr_req;
	logic              wr_req_ready;
	logic              wr_rsp_valid;
	soc_pkg::resp_e    wr_rsp;
	logic              wr_rsp_ready;
	logic              uart_tx_valid;
	logic [7:0]        uart_tx_byte;

	soc_pkg::bus_rsp_t exp_inst;
	soc_pkg::bus_rsp_t exp_rd;
	soc_pkg::resp_e    exp_wr;
	logic [7:0]        exp_tx_byte;
	soc_pkg::data_t    ref_mem [2**SRAM_AW];	// reference sram image
	logic [31:0]       rng;
	int unsigned       cyc;	// cycles since reset, tracks mtime
	int unsigned       tx_count;

	soc_top #(
		.SRAM_AW (SRAM_AW)
	) DUT (
		.clock            (clock),
		.rst_n_i          (rst_n),
		.inst_req_valid_i (inst_req_valid),
		.inst_req_addr_i  (inst_req_addr),
		.inst_req_ready_o (inst_req_ready),
		.inst_rsp_valid_o (inst_rsp_valid),
		.inst_rsp_o       (inst_rsp),
		.inst_rsp_ready_i (inst_rsp_ready),
		.rd_req_valid_i   (rd_req_valid),
		.rd_req_addr_i    (rd_req_addr),
		.rd_req_ready_o   (rd_req_ready),
		.rd_rsp_valid_o   (rd_rsp_valid),
		.rd_rsp_o         (rd_rsp),
		.rd_rsp_ready_i   (rd_rsp_ready),
		.wr_req_valid_i   (wr_req_valid),
		.wr_req_i         (wr_req),
		.wr_req_ready_o   (wr_req_ready),
		.wr_rsp_valid_o   (wr_rsp_valid),
		.wr_rsp_o         (wr_rsp),
		.wr_rsp_ready_i   (wr_rsp_ready),
		.uart_tx_valid_o  (uart_tx_valid),
		.uart_tx_byte_o   (uart_tx_byte)
	);

	always #(CLK_PERIOD / 2) clock = ~clock;

	always @(posedge clock) begin
		if (!rst_n)
			cyc <= 0;
		else
			cyc <= cyc + 1;
		if (uart_tx_valid)
			tx_count <= tx_count + 1;
	end

	function automatic logic [31:0] xorshift32(input logic [31:0] x);
		logic [31:0] y;
		y = x ^ (x << 13);
		y = y ^ (y >> 17);
		y = y ^ (y << 5);
		return y;
	endfunction

	// byte lanes with strb set take the new data
	function automatic soc_pkg::data_t merge_bytes(input soc_pkg::data_t old,
			input soc_pkg::data_t data, input soc_pkg::strb_t strb);
		soc_pkg::data_t w;
		w = old;
		for (int b = 0; b < 4; b++) begin
			if (strb[b])
				w[b*8 +: 8] = data[b*8 +: 8];
		end
		return w;
	endfunction

	// spread the test words over the whole window
	function automatic int word_idx(input int k);
		return (k * 37 + 5) % (2**SRAM_AW);
	endfunction

	function automatic soc_pkg::addr_t sram_addr(input int k);
		return soc_pkg::SRAM_BASE + soc_pkg::addr_t'(word_idx(k) << 2);
	endfunction

	task automatic report_mismatch(input string name, input logic [31:0] got,
			input logic [31:0] exp);
		$display("FAIL %s: got 0x%08h, expected 0x%08h", name, got, exp);
		$display("TB FAILED");
		$fatal(1, "%s mismatch", name);
	endtask

	task automatic report_error(input string what);
		$display("error: %s", what);
		$display("TB FAILED");
		$fatal(1, "%s", what);
	endtask

	// hold is the number of cycles the response ready stays low
	task automatic write_txn(input soc_pkg::addr_t addr, input soc_pkg::data_t data,
			input soc_pkg::strb_t strb, input soc_pkg::resp_e exp_resp, input int hold);
		exp_wr = exp_resp;
		wr_rsp_ready = (hold == 0);
		wr_req.addr = addr;
		wr_req.data = data;
		wr_req.strb = strb;
		wr_req_valid = 1'b1;
		@(negedge clock);
		while (!wr_req_ready)
			@(negedge clock);
		@(posedge clock);
		#1;
		wr_req_valid = 1'b0;
		@(negedge clock);
		while (!wr_rsp_valid)
			@(negedge clock);
		if (hold > 0) begin
			repeat (hold) @(posedge clock);
			#1;
			wr_rsp_ready = 1'b1;
		end
		@(posedge clock);
		#1;
	endtask

	task automatic read_txn(input soc_pkg::addr_t addr, input soc_pkg::data_t exp_data,
			input soc_pkg::resp_e exp_resp, input int hold);
		exp_rd.data = exp_data;
		exp_rd.resp = exp_resp;
		rd_rsp_ready = (hold == 0);
		rd_req_addr = addr;
		rd_req_valid = 1'b1;
		@(negedge clock);
		while (!rd_req_ready)
			@(negedge clock);
		@(posedge clock);
		#1;
		rd_req_valid = 1'b0;
		@(negedge clock);
		while (!rd_rsp_valid)
			@(negedge clock);
		if (hold > 0) begin
			repeat (hold) @(posedge clock);
			#1;
			rd_rsp_ready = 1'b1;
		end
		@(posedge clock);
		#1;
	endtask

	task automatic fetch_txn(input soc_pkg::addr_t addr, input soc_pkg::data_t exp_data,
			input soc_pkg::resp_e exp_resp, input int hold);
		exp_inst.data = exp_data;
		exp_inst.resp = exp_resp;
		inst_rsp_ready = (hold == 0);
		inst_req_addr = addr;
		inst_req_valid = 1'b1;
		@(negedge clock);
		while (!inst_req_ready)
			@(negedge clock);
		@(posedge clock);
		#1;
		inst_req_valid = 1'b0;
		@(negedge clock);
		while (!inst_rsp_valid)
			@(negedge clock);
		if (hold > 0) begin
			repeat (hold) @(posedge clock);
			#1;
			inst_rsp_ready = 1'b1;
		end
		@(posedge clock);
		#1;
	endtask

	task automatic sram_write(input int k, input soc_pkg::data_t data,
			input soc_pkg::strb_t strb, input int hold);
		ref_mem[word_idx(k)] = merge_bytes(ref_mem[word_idx(k)], data, strb);
		write_txn(sram_addr(k), data, strb, soc_pkg::RESP_OKAY, hold);
	endtask

	// response payloads
	inst_data_ok: assert property (@(posedge clock) disable iff (!rst_n)
		inst_rsp_valid |-> inst_rsp.data == exp_inst.data)
		else report_mismatch("inst_rsp_o.data", $sampled(inst_rsp.data), $sampled(exp_inst.data));
	inst_resp_ok: assert property (@(posedge clock) disable iff (!rst_n)
		inst_rsp_valid |-> inst_rsp.resp == exp_inst.resp)
		else report_mismatch("inst_rsp_o.resp", $sampled(inst_rsp.resp), $sampled(exp_inst.resp));
	rd_data_ok: assert property (@(posedge clock) disable iff (!rst_n)
		rd_rsp_valid |-> rd_rsp.data == exp_rd.data)
		else report_mismatch("rd_rsp_o.data", $sampled(rd_rsp.data), $sampled(exp_rd.data));
	rd_resp_ok: assert property (@(posedge clock) disable iff (!rst_n)
		rd_rsp_valid |-> rd_rsp.resp == exp_rd.resp)
		else report_mismatch("rd_rsp_o.resp", $sampled(rd_rsp.resp), $sampled(exp_rd.resp));
	wr_resp_ok: assert property (@(posedge clock) disable iff (!rst_n)
		wr_rsp_valid |-> wr_rsp == exp_wr)
		else report_mismatch("wr_rsp_o", $sampled(wr_rsp), $sampled(exp_wr));

	// response two cycles after the request transfer
	inst_latency: assert property (@(posedge clock) disable iff (!rst_n)
		inst_req_valid && inst_req_ready |=> !inst_rsp_valid ##1 inst_rsp_valid)
		else report_error("fetch response not 2 cycles after request");
	rd_latency: assert property (@(posedge clock) disable iff (!rst_n)
		rd_req_valid && rd_req_ready |=> !rd_rsp_valid ##1 rd_rsp_valid)
		else report_error("data read response not 2 cycles after request");
	wr_latency: assert property (@(posedge clock) disable iff (!rst_n)
		wr_req_valid && wr_req_ready |=> !wr_rsp_valid ##1 wr_rsp_valid)
		else report_error("write response not 2 cycles after request");

	// held response under back-pressure
	inst_hold: assert property (@(posedge clock) disable iff (!rst_n)
		inst_rsp_valid && !inst_rsp_ready |=> inst_rsp_valid && $stable(inst_rsp))
		else report_error("fetch response dropped or changed while stalled");
	rd_hold: assert property (@(posedge clock) disable iff (!rst_n)
		rd_rsp_valid && !rd_rsp_ready |=> rd_rsp_valid && $stable(rd_rsp))
		else report_error("data read response dropped or changed while stalled");
	wr_hold: assert property (@(posedge clock) disable iff (!rst_n)
		wr_rsp_valid && !wr_rsp_ready |=> wr_rsp_valid && $stable(wr_rsp))
		else report_error("write response dropped or changed while stalled");

	// fixed priority and one transaction at a time
	wr_first: assert property (@(posedge clock) disable iff (!rst_n)
		wr_req_valid |-> !rd_req_ready && !inst_req_ready)
		else report_error("read or fetch granted over a pending write");
	rd_before_fetch: assert property (@(posedge clock) disable iff (!rst_n)
		rd_req_valid |-> !inst_req_ready)
		else report_error("fetch granted over a pending data read");
	busy_no_grant: assert property (@(posedge clock) disable iff (!rst_n)
		(inst_rsp_valid || rd_rsp_valid || wr_rsp_valid)
		|-> !(inst_req_ready || rd_req_ready || wr_req_ready))
		else report_error("request accepted while a response is outstanding");

	uart_byte_ok: assert property (@(posedge clock) disable iff (!rst_n)
		uart_tx_valid |-> uart_tx_byte == exp_tx_byte)
		else report_mismatch("uart_tx_byte_o", $sampled(uart_tx_byte), $sampled(exp_tx_byte));
	uart_one_pulse: assert property (@(posedge clock) disable iff (!rst_n)
		uart_tx_valid |=> !uart_tx_valid)
		else report_error("uart tx valid longer than one cycle");

	initial begin
		#(WATCHDOG_NS);
		$display("TB FAILED");
		$fatal(1, "watchdog expired, a transaction never completed");
	end

	initial begin
		soc_pkg::data_t d;
		int unsigned    t0;
		clock = 1'b0;
		rst_n = 1'b0;
		inst_req_valid = 1'b0;
		inst_req_addr = '0;
		inst_rsp_ready = 1'b1;
		rd_req_valid = 1'b0;
		rd_req_addr = '0;
		rd_rsp_ready = 1'b1;
		wr_req_valid = 1'b0;
		wr_req = '0;
		wr_rsp_ready = 1'b1;
		exp_inst = '0;
		exp_rd = '0;
		exp_wr = soc_pkg::RESP_OKAY;
		exp_tx_byte = '0;
		rng = 32'h5306;
		tx_count = 0;
		repeat (RESET_CYCLES) @(posedge clock);
		#1;
		rst_n = 1'b1;
		@(negedge clock);
		assert (!inst_req_ready && !inst_rsp_valid && !rd_req_ready && !rd_rsp_valid
			&& !wr_req_ready && !wr_rsp_valid && !uart_tx_valid)
			else report_error("a ready or valid output is high after reset");
		@(posedge clock);
		#1;

		// fill with full words first so no byte stays unknown
		for (int i = 0; i < N_WORDS; i++) begin
			rng = xorshift32(rng);
			sram_write(i, rng, 4'hf, 0);
		end
		for (int i = 0; i < N_RAND; i++) begin
			rng = xorshift32(rng);
			d = rng;
			rng = xorshift32(rng);
			sram_write(rng[7:0] % N_WORDS, d, rng[11:8], i % 3);
		end
		for (int i = 0; i < N_WORDS; i++)
			read_txn(sram_addr(i), ref_mem[word_idx(i)], soc_pkg::RESP_OKAY, i % 2);

		for (int i = 0; i < N_FETCH; i++) begin
			fetch_txn(sram_addr(i), ref_mem[word_idx(i)], soc_pkg::RESP_OKAY, 0);
			read_txn(sram_addr(i), ref_mem[word_idx(i)], soc_pkg::RESP_OKAY, 0);
		end

		for (int i = 0; i < 2; i++) begin
			rng = xorshift32(rng);
			exp_tx_byte = rng[7:0];
			t0 = tx_count;
			write_txn(soc_pkg::UART_TX_ADDR, rng, 4'hf, soc_pkg::RESP_OKAY, 0);
			assert (tx_count == t0 + 1)
				else report_error("uart write did not give exactly one tx pulse");
		end

		// idle port is granted at once and mtime is taken one cycle later
		read_txn(soc_pkg::CLINT_MTIME_LO, cyc + 1, soc_pkg::RESP_OKAY, 0);
		repeat (7) @(posedge clock);
		#1;
		read_txn(soc_pkg::CLINT_MTIME_LO, cyc + 1, soc_pkg::RESP_OKAY, 2);
		read_txn(soc_pkg::CLINT_MTIME_HI, '0, soc_pkg::RESP_OKAY, 0);

		t0 = tx_count;
		read_txn(32'h4000_0000, '0, soc_pkg::RESP_DECERR, 0);
		write_txn(sram_addr(0) + (4 << SRAM_AW), 32'hdead_beef, 4'hf,
			soc_pkg::RESP_DECERR, 0);	// just past the sram window, aliases test word 0
		read_txn(soc_pkg::UART_TX_ADDR, '0, soc_pkg::RESP_DECERR, 1);
		write_txn(soc_pkg::CLINT_MTIME_LO, 32'h1234_5678, 4'hf, soc_pkg::RESP_DECERR, 1);
		assert (tx_count == t0)
			else report_error("uart pulsed on a rejected access");
		for (int i = 0; i < N_WORDS; i++)
			read_txn(sram_addr(i), ref_mem[word_idx(i)], soc_pkg::RESP_OKAY, 0);

		// all ports at once on one word so the reads must see the write
		for (int r = 0; r < 2; r++) begin
			rng = xorshift32(rng);
			d = rng;
			ref_mem[word_idx(r)] = d;
			fork
				write_txn(sram_addr(r), d, 4'hf, soc_pkg::RESP_OKAY, 3);
				read_txn(sram_addr(r), d, soc_pkg::RESP_OKAY, 2);
				fetch_txn(sram_addr(r), d, soc_pkg::RESP_OKAY, 4);
			join
		end

		repeat (4) @(posedge clock);
		$display("TB PASSED");
		$finish;
	end

endmodule

//--- flist.f
hdl/soc_pkg.sv
hdl/sram_dev.sv
hdl/uart_dev.sv
hdl/clint_dev.sv
hdl/addr_xbar.sv
hdl/bus_ctl.sv
hdl/soc_top.sv
bench/soc_tb.sv
